/* include/cab_defines.svh */
`ifndef CAB_DEFINES_SVH
`define CAB_DEFINES_SVH

// Game identifier codes as seen on game_id
`define CAB_GAME_GENERIC   8'h00
`define CAB_GAME_HWCHAMP   8'h11  // Boxing handle
`define CAB_GAME_PASSSHT   8'h12  // Four players with pass layout
`define CAB_GAME_DUNKSHOT  8'h14  // Trackball
`define CAB_GAME_BULLET    8'h18  // Three players

// Trackball counter values after reset
`define CAB_TB_RESET0      12'h10a
`define CAB_TB_RESET1      12'h20b
`define CAB_TB_RESET2      12'h30c
`define CAB_TB_RESET3      12'h40d
`define CAB_TB_RESET4      12'h50e
`define CAB_TB_RESET5      12'h60f
`define CAB_TB_RESET6      12'h701
`define CAB_TB_RESET7      12'h802

// Horizontal blanks between two trackball updates
`define CAB_TB_INTERVAL    64

`endif

/* hdl/cab_pkg.sv */
`include "cab_defines.svh"

package cab_pkg;

    // Supported cabinet layouts
    typedef enum logic [2:0] {
        GAME_GENERIC,
        GAME_BULLET,   // Three players with nibble swap
        GAME_PASSSHT,  // Pass layout in custom region
        GAME_DUNKSHOT, // Trackball
        GAME_HWCHAMP   // Boxing handle
    } game_t;

    // Formatted digital inputs, one byte each
    typedef struct packed {
        logic [7:0] sys;
        logic [7:0] p1;
        logic [7:0] p2;
        logic [7:0] p3;
        logic [7:0] pass0;
        logic [7:0] pass1;
        logic [7:0] pass2;
        logic [7:0] pass3;
    } joy_bytes_t;

    // Serial register load source coded as addr 2..1
    typedef enum logic [1:0] {
        ANA_MONITOR = 2'd0,
        ANA_LEFT    = 2'd1,
        ANA_RIGHT   = 2'd2,
        ANA_IDLE    = 2'd3
    } ana_sel_t;

    function automatic game_t decode_game(input logic [7:0] id);
        case (id)
            `CAB_GAME_GENERIC:  return GAME_GENERIC;
            `CAB_GAME_BULLET:   return GAME_BULLET;
            `CAB_GAME_PASSSHT:  return GAME_PASSSHT;
            `CAB_GAME_DUNKSHOT: return GAME_DUNKSHOT;
            `CAB_GAME_HWCHAMP:  return GAME_HWCHAMP;
            default:            return GAME_GENERIC; // Unknown titles
        endcase
    endfunction

endpackage

/* hdl/cab_analog_if.sv */
`timescale 1ns/100ps

interface cab_analog_if;
    import cab_pkg::*;

    logic        load;      // One-cycle strobe
    ana_sel_t    load_sel;
    logic        shift;     // One-cycle strobe never paired with load
    logic [2:0]  tb_idx;
    logic [11:0] tb_word;   // Counter picked by tb_idx
    logic        ser_bit;   // MSB of the serial register

    modport mux (
        output load,
        output load_sel,
        output shift,
        output tb_idx,
        input  tb_word,
        input  ser_bit
    );

    modport unit (
        input  load,
        input  load_sel,
        input  shift,
        input  tb_idx,
        output tb_word,
        output ser_bit
    );

endinterface

/* hdl/joy_formatter.sv */
`timescale 1ns/100ps

module joy_formatter (
    input  logic                clk,
    input  logic                rst,
    input  cab_pkg::game_t      game,
    input  logic [7:0]          joystick1,
    input  logic [7:0]          joystick2,
    input  logic [7:0]          joystick3,
    input  logic [7:0]          joystick4,
    input  logic [3:0]          start_button,
    input  logic [3:0]          coin_input,
    input  logic                service,
    input  logic                dip_test,
    output logic [7:0]          sys_inputs,
    output cab_pkg::joy_bytes_t joy
);
    import cab_pkg::*;

    logic [7:0] joy_m [4];
    logic [7:0] joy_s [4];
    logic [3:0] start_m, start_s;
    logic [3:0] coin_m, coin_s;
    logic [1:0] misc_m, misc_s;  // {service, dip_test}

    function automatic logic [7:0] sort_joy(input logic [7:0] j);
        return {j[1:0], j[3:2], j[7], j[5:4], j[6]};
    endfunction

    function automatic logic [7:0] swap_nib(input logic [7:0] b);
        return {b[3:0], b[7:4]};
    endfunction

    function automatic logic [7:0] pass_joy(input logic [7:0] j);
        return {j[7:4], j[1:0], j[3:2]};
    endfunction

    // Two-flop synchronizer with switches idling high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            joy_m   <= '{default: 8'hff};
            joy_s   <= '{default: 8'hff};
            start_m <= '1;
            start_s <= '1;
            coin_m  <= '1;
            coin_s  <= '1;
            misc_m  <= '1;
            misc_s  <= '1;
        end else begin
            joy_m   <= '{joystick1, joystick2, joystick3, joystick4};
            joy_s   <= joy_m;
            start_m <= start_button;
            start_s <= start_m;
            coin_m  <= coin_input;
            coin_s  <= coin_m;
            misc_m  <= {service, dip_test};
            misc_s  <= misc_m;
        end
    end

    assign sys_inputs = {2'b11, start_s[1:0], misc_s, coin_s[1:0]};

    always_comb begin
        joy.sys   = sys_inputs;
        joy.p1    = sort_joy(joy_s[0]);
        joy.p2    = sort_joy(joy_s[1]);
        joy.p3    = 8'hff;            // Only wired on three-player cabinets
        joy.pass0 = pass_joy(joy_s[0]);
        joy.pass1 = pass_joy(joy_s[1]);
        joy.pass2 = pass_joy(joy_s[2]);
        joy.pass3 = pass_joy(joy_s[3]);
        case (game)
            GAME_BULLET: begin
                joy.sys[7:6] = {coin_s[2], start_s[2]};
                joy.p1       = swap_nib(sort_joy(joy_s[0]));
                joy.p2       = swap_nib(sort_joy(joy_s[1]));
                joy.p3       = swap_nib(sort_joy(joy_s[2]));
            end
            GAME_PASSSHT: joy.sys[7:6] = start_s[3:2];
            GAME_DUNKSHOT: begin
                joy.sys[7:6] = start_s[3:2];
                // Button pairs, player 4 on top
                joy.p1 = {joy_s[3][5:4], joy_s[2][5:4], joy_s[1][5:4], joy_s[0][5:4]};
            end
            default: ;
        endcase
    end

endmodule

/* hdl/analog_unit.sv */
`timescale 1ns/100ps
`include "cab_defines.svh"

module analog_unit (
    input  logic           clk,
    input  logic           rst,
    input  logic           lhbl,
    input  cab_pkg::game_t game,
    input  logic [15:0]    joyana1,
    input  logic [15:0]    joyana2,
    input  logic [15:0]    joyana3,
    input  logic [15:0]    joyana4,
    input  logic [15:0]    joyana1b,
    cab_analog_if.unit     ana
);
    import cab_pkg::*;

    localparam int LINE_W = $clog2(`CAB_TB_INTERVAL);
    localparam logic [11:0] TB_RESET [8] = '{
        `CAB_TB_RESET0, `CAB_TB_RESET1, `CAB_TB_RESET2, `CAB_TB_RESET3,
        `CAB_TB_RESET4, `CAB_TB_RESET5, `CAB_TB_RESET6, `CAB_TB_RESET7
    };

    logic [11:0]       tb_cnt [8];
    logic [15:0]       stick [4];
    logic              lhbl_l;
    logic              lhbl_fall;
    logic [LINE_W-1:0] line_cnt;
    logic [7:0]        mon_sum;
    logic [7:0]        monitor_val;
    logic [7:0]        left_val;
    logic [7:0]        right_val;
    logic [7:0]        ser_reg;

    // Bits 6..3 of an axis extended with its sign bit
    function automatic logic [11:0] ext_axis(input logic [7:0] a);
        return {{8{a[7]}}, a[6:3]};
    endfunction

    // Handle rests at 20h and pushing is scaled harder than pulling
    function automatic logic [7:0] handle(input logic [7:0] a);
        if (!a[7])
            return 8'h20 - {3'd0, a[6:2]};
        else
            return ~({1'b0, a[6:0]} + {2'b0, a[6:1]} + {3'b0, a[6:2]});
    endfunction

    assign stick[0] = joyana1;
    assign stick[1] = joyana2;
    assign stick[2] = joyana3;
    assign stick[3] = joyana4;

    assign lhbl_fall = lhbl_l & ~lhbl;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lhbl_l   <= 1'b0;
            line_cnt <= '0;
            for (int i = 0; i < 8; i++)
                tb_cnt[i] <= TB_RESET[i];
        end else begin
            lhbl_l <= lhbl;
            if (lhbl_fall && game == GAME_DUNKSHOT) begin
                if (line_cnt == LINE_W'(`CAB_TB_INTERVAL - 1))
                    line_cnt <= '0;
                else
                    line_cnt <= line_cnt + 1'b1;
                if (line_cnt == '0) begin
                    for (int i = 0; i < 4; i++) begin
                        tb_cnt[2*i]   <= tb_cnt[2*i]   - ext_axis(stick[i][7:0]);  // X
                        tb_cnt[2*i+1] <= tb_cnt[2*i+1] + ext_axis(stick[i][15:8]); // Y
                    end
                end
            end
        end
    end

    assign mon_sum     = {joyana1[7], joyana1[7:1]} + {joyana1b[7], joyana1b[7:1]};
    assign monitor_val = {~mon_sum[7], mon_sum[6:0]};
    assign left_val    = handle(joyana1b[15:8]);
    assign right_val   = handle(joyana1[15:8]);

    // Serial register read out MSB first
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ser_reg <= 8'hff;
        end else if (ana.load) begin
            case (ana.load_sel)
                ANA_MONITOR: ser_reg <= monitor_val;
                ANA_LEFT:    ser_reg <= left_val;
                ANA_RIGHT:   ser_reg <= right_val;
                default:     ser_reg <= 8'hff;
            endcase
        end else if (ana.shift) begin
            ser_reg <= {ser_reg[6:0], 1'b0};
        end
    end

    assign ana.tb_word = tb_cnt[ana.tb_idx];
    assign ana.ser_bit = ser_reg[7];

endmodule

/* hdl/cab_read_mux.sv */
`timescale 1ns/100ps

module cab_read_mux (
    input  logic                clk,
    input  logic                rst,
    input  cab_pkg::game_t      game,
    input  logic [23:1]         addr,
    input  logic [15:0]         cpu_dout,
    input  logic                ldswn,
    input  logic                udswn,
    input  logic                ldsn,
    input  logic                udsn,
    input  logic                io_cs,
    input  logic [7:0]          dipsw_a,
    input  logic [7:0]          dipsw_b,
    input  cab_pkg::joy_bytes_t joy,
    cab_analog_if.mux           ana,
    output logic [7:0]          cab_dout,
    output logic                flip,
    output logic                video_en
);
    import cab_pkg::*;

    logic [1:0] region;
    logic       wr;
    logic       hw_access;  // Boxing-handle serial port hit
    logic       shift_en;   // Shift armed by a serial read
    logic [7:0] rd_byte;

    assign region = addr[13:12];
    assign wr     = ~ldswn | ~udswn;

    assign hw_access = io_cs && region == 2'd3 && game == GAME_HWCHAMP
                       && addr[5:4] == 2'd2 && (!ldsn || !udsn);

    assign ana.load     = hw_access & wr;
    assign ana.load_sel = ana_sel_t'(addr[2:1]);
    assign ana.shift    = shift_en & ~io_cs;  // Waits for the access to end
    assign ana.tb_idx   = addr[4:2];

    always_comb begin
        rd_byte = 8'hff;
        if (io_cs) begin
            case (region)
                2'd1: begin
                    case (addr[2:1])
                        2'd0: rd_byte = joy.sys;
                        2'd1: rd_byte = joy.p1;
                        2'd2: rd_byte = joy.p3;
                        2'd3: rd_byte = joy.p2;
                    endcase
                end
                2'd2: rd_byte = addr[1] ? dipsw_a : dipsw_b;
                2'd3: begin
                    case (game)
                        GAME_PASSSHT: begin
                            if (addr[9:8] == 2'd2) begin
                                case (addr[2:1])
                                    2'd0: rd_byte = joy.pass0;
                                    2'd1: rd_byte = joy.pass1;
                                    2'd2: rd_byte = joy.pass2;
                                    2'd3: rd_byte = joy.pass3;
                                endcase
                            end
                        end
                        GAME_DUNKSHOT:
                            rd_byte = !addr[1] ? ana.tb_word[7:0] : {4'd0, ana.tb_word[11:8]};
                        GAME_HWCHAMP:
                            if (hw_access && !wr)
                                rd_byte = {7'd0, ana.ser_bit};
                        default: ;
                    endcase
                end
                default: ;  // Region 0 is write only
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cab_dout <= 8'hff;
            flip     <= 1'b0;
            video_en <= 1'b1;
            shift_en <= 1'b0;
        end else begin
            cab_dout <= rd_byte;
            if (io_cs && region == 2'd0 && !ldswn) begin
                flip     <= cpu_dout[6];
                video_en <= cpu_dout[5];
            end
            if (ana.shift)
                shift_en <= 1'b0;
            else if (hw_access && !wr)
                shift_en <= 1'b1;
        end
    end

endmodule

/* hdl/cab_io.sv */
`timescale 1ns/100ps

module cab_io (
    input  logic        clk,
    input  logic        rst,
    input  logic        lhbl,
    input  logic [7:0]  game_id,
    input  logic [23:1] addr,
    input  logic [15:0] cpu_dout,
    input  logic        ldswn,
    input  logic        udswn,
    input  logic        ldsn,
    input  logic        udsn,
    input  logic        io_cs,
    input  logic        dip_test,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    input  logic [7:0]  joystick1,
    input  logic [7:0]  joystick2,
    input  logic [7:0]  joystick3,
    input  logic [7:0]  joystick4,
    input  logic [15:0] joyana1,
    input  logic [15:0] joyana1b,  // Second handle on the boxing cabinet
    input  logic [15:0] joyana2,
    input  logic [15:0] joyana3,
    input  logic [15:0] joyana4,
    input  logic [3:0]  start_button,
    input  logic [3:0]  coin_input,
    input  logic        service,
    output logic [7:0]  sys_inputs,
    output logic [7:0]  cab_dout,
    output logic        flip,
    output logic        video_en
);
    import cab_pkg::*;

    game_t      game;
    joy_bytes_t joy;

    cab_analog_if ana_if ();

    assign game = decode_game(game_id);

    joy_formatter u_joy (
        .clk(clk), .rst(rst), .game(game),
        .joystick1(joystick1), .joystick2(joystick2),
        .joystick3(joystick3), .joystick4(joystick4),
        .start_button(start_button), .coin_input(coin_input),
        .service(service), .dip_test(dip_test),
        .sys_inputs(sys_inputs), .joy(joy)
    );

    analog_unit u_ana (
        .clk(clk), .rst(rst), .lhbl(lhbl), .game(game),
        .joyana1(joyana1), .joyana2(joyana2), .joyana3(joyana3),
        .joyana4(joyana4), .joyana1b(joyana1b),
        .ana(ana_if.unit)
    );

    cab_read_mux u_mux (
        .clk(clk), .rst(rst), .game(game),
        .addr(addr), .cpu_dout(cpu_dout),
        .ldswn(ldswn), .udswn(udswn), .ldsn(ldsn), .udsn(udsn),
        .io_cs(io_cs), .dipsw_a(dipsw_a), .dipsw_b(dipsw_b),
        .joy(joy), .ana(ana_if.mux),
        .cab_dout(cab_dout), .flip(flip), .video_en(video_en)
    );

endmodule

/* testbench/cab_io_asserts.sv */
`timescale 1ns/100ps

module cab_io_asserts (
    input logic       clk,
    input logic       rst,
    input logic       io_cs,
    input logic [1:0] region,
    input logic       ldswn,
    input logic       shift,
    input logic [7:0] cab_dout,
    input logic       flip,
    input logic       video_en
);
    int fail_count = 0;

    // Idle bus reads back all ones
    idle_high: assert property (@(posedge clk) disable iff (rst) !io_cs |=> cab_dout == 8'hff)
        else begin
            $error("cab_dout is not 8'hff after a cycle without io_cs");
            fail_count++;
        end

    // Serial shift only in the first cycle after an access
    shift_after_access: assert property (@(posedge clk) disable iff (rst)
        shift |-> $past(io_cs))
        else begin
            $error("shift fired without an access in the cycle before");
            fail_count++;
        end

    reset_values: assert property (@(posedge clk) rst |=> cab_dout == 8'hff && !flip && video_en)
        else begin
            $error("outputs do not hold their reset values");
            fail_count++;
        end

    // Flip moves only on a control write
    flip_on_write: assert property (@(posedge clk) disable iff (rst)
        flip != $past(flip) |-> $past(io_cs && region == 2'd0 && !ldswn))
        else begin
            $error("flip changed without a region 0 write");
            fail_count++;
        end

endmodule

/* testbench/cab_checker.sv */
`timescale 1ns/100ps

module cab_checker (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] cab_dout,
    input  logic       flip,
    input  logic       video_en,
    input  logic [7:0] sys_inputs,
    input  logic [1:0] chk_sel,    // 1 read byte, 2 control bits, 3 system byte
    input  logic [7:0] chk_exp,
    input  logic       test_done,
    input  int         test_id,
    output int         errors,
    output int         checks,
    output int         bad_tests
);
    logic [1:0] sel_q;
    logic [7:0] exp_q;
    int         test_checks;
    int         test_errors;

    task automatic log_mismatch(input string sig, input logic [7:0] got, input logic [7:0] exp);
        $display("** Error at %0t ns: %s = %h, expected %h", $time, sig, got, exp);
        errors++;
        test_errors++;
    endtask

    // Request taken with the access and checked one cycle later
    always @(posedge clk) begin
        sel_q <= chk_sel;
        exp_q <= chk_exp;
    end

    always @(negedge clk) begin
        if (rst) begin
            errors      = 0;
            checks      = 0;
            bad_tests   = 0;
            test_checks = 0;
            test_errors = 0;
        end else begin
            if (sel_q != 2'd0) begin
                checks++;
                test_checks++;
            end
            if (sel_q == 2'd1 && cab_dout !== exp_q)
                log_mismatch("cab_dout", cab_dout, exp_q);
            if (sel_q == 2'd2 && flip !== exp_q[1])
                log_mismatch("flip", {7'd0, flip}, {7'd0, exp_q[1]});
            if (sel_q == 2'd2 && video_en !== exp_q[0])
                log_mismatch("video_en", {7'd0, video_en}, {7'd0, exp_q[0]});
            if (sel_q == 2'd3 && sys_inputs !== exp_q)
                log_mismatch("sys_inputs", sys_inputs, exp_q);
            if (test_done) begin
                if (test_checks == 0)
                    $display("Test %0d FAILED: no checks were made", test_id);
                else
                    $display("Test %0d %s: %0d checks, %0d errors", test_id,
                             test_errors == 0 ? "ok" : "FAILED", test_checks, test_errors);
                if (test_errors != 0 || test_checks == 0)
                    bad_tests++;
                test_checks = 0;
                test_errors = 0;
            end
        end
    end

endmodule

/* testbench/tb_cab_io.sv */
`timescale 1ns/100ps
`include "cab_defines.svh"

module tb_cab_io;

    localparam int CLK_PERIOD = 40;
    localparam int MAX_EDGES  = 200;
    // Rough cycle count of reset, control, 5 games, pass, trackball and boxing
    localparam int RUN_CYCLES = 30 + 5 * 19 + 20 + (MAX_EDGES * 4 + 40) + 4 * 18 + 10;
    localparam logic [11:0] TB_INIT [8] = '{
        `CAB_TB_RESET0, `CAB_TB_RESET1, `CAB_TB_RESET2, `CAB_TB_RESET3,
        `CAB_TB_RESET4, `CAB_TB_RESET5, `CAB_TB_RESET6, `CAB_TB_RESET7
    };
    localparam logic [7:0] GAME_CODES [5] = '{
        `CAB_GAME_GENERIC, `CAB_GAME_BULLET, `CAB_GAME_PASSSHT,
        `CAB_GAME_DUNKSHOT, `CAB_GAME_HWCHAMP
    };

    logic        clk = 1'b0;
    logic        rst;
    logic        lhbl;
    logic [7:0]  game_id;
    logic [23:1] addr;
    logic [15:0] cpu_dout;
    logic        ldswn, udswn, ldsn, udsn, io_cs;
    logic        service_sw, test_sw;
    logic [7:0]  dip_a, dip_b;
    logic [7:0]  js [4];
    logic [15:0] sticks [4];
    logic [15:0] stick1b;       // Second boxing handle
    logic [3:0]  start_btn, coin;
    logic [7:0]  sys_inputs, cab_dout;
    logic        flip, video_en;
    logic [1:0]  chk_sel;
    logic [7:0]  chk_exp;
    logic        test_done;
    int          test_id;
    int          errors, checks, bad_tests;
    integer      seed = 32'h037a62e0;
    int          tb_updates;    // Trackball updates seen so far
    logic [7:0]  ser_exp;       // Model of the serial register

    cab_io DUT (
        .clk(clk), .rst(rst), .lhbl(lhbl), .game_id(game_id),
        .addr(addr), .cpu_dout(cpu_dout),
        .ldswn(ldswn), .udswn(udswn), .ldsn(ldsn), .udsn(udsn), .io_cs(io_cs),
        .dip_test(test_sw), .dipsw_a(dip_a), .dipsw_b(dip_b),
        .joystick1(js[0]), .joystick2(js[1]), .joystick3(js[2]), .joystick4(js[3]),
        .joyana1(sticks[0]), .joyana1b(stick1b), .joyana2(sticks[1]),
        .joyana3(sticks[2]), .joyana4(sticks[3]),
        .start_button(start_btn), .coin_input(coin), .service(service_sw),
        .sys_inputs(sys_inputs), .cab_dout(cab_dout), .flip(flip), .video_en(video_en)
    );

    cab_checker u_checker (
        .clk(clk), .rst(rst), .cab_dout(cab_dout), .flip(flip), .video_en(video_en),
        .sys_inputs(sys_inputs),
        .chk_sel(chk_sel), .chk_exp(chk_exp), .test_done(test_done), .test_id(test_id),
        .errors(errors), .checks(checks), .bad_tests(bad_tests)
    );

    bind cab_read_mux cab_io_asserts u_asserts (
        .clk(clk), .rst(rst), .io_cs(io_cs), .region(addr[13:12]), .ldswn(ldswn),
        .shift(ana.shift),
        .cab_dout(cab_dout), .flip(flip), .video_en(video_en)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [23:1] region_addr(input logic [1:0] r, input logic [11:1] low);
        return {10'd0, r, low};
    endfunction

    function automatic logic [7:0] order_bits(input logic [7:0] j);
        return {j[1], j[0], j[3], j[2], j[7], j[5], j[4], j[6]};
    endfunction

    // System byte before any per-game replacement
    function automatic logic [7:0] plain_sys();
        return {2'b11, start_btn[1], start_btn[0], service_sw, test_sw, coin[1], coin[0]};
    endfunction

    function automatic logic [7:0] handle_expect(input logic [7:0] a);
        int v;
        v = a[6:0];
        if (!a[7])
            return 8'(32 - (v >> 2));
        return ~8'(v + (v >> 1) + (v >> 2));
    endfunction

    function automatic logic [7:0] load_expect(input logic [1:0] sel);
        int m;
        m = ($signed(sticks[0][7:0]) >>> 1) + ($signed(stick1b[7:0]) >>> 1);
        case (sel)
            2'd0:    return 8'(m) ^ 8'h80;
            2'd1:    return handle_expect(stick1b[15:8]);
            2'd2:    return handle_expect(sticks[0][15:8]);
            default: return 8'hff;
        endcase
    endfunction

    // Expected read byte for the current game and switch state
    function automatic logic [7:0] cab_expect(input logic [23:1] a);
        logic [7:0]  sys;
        logic [7:0]  p [3];
        logic [7:0]  ax;
        logic [11:0] cnt;
        logic [2:0]  idx;
        int          i;
        int          step;
        sys = plain_sys();
        if (game_id == `CAB_GAME_BULLET)
            sys[7:6] = {coin[2], start_btn[2]};
        else if (game_id == `CAB_GAME_PASSSHT || game_id == `CAB_GAME_DUNKSHOT)
            sys[7:6] = {start_btn[3], start_btn[2]};
        for (i = 0; i < 3; i++) begin
            p[i] = order_bits(js[i]);
            if (game_id == `CAB_GAME_BULLET)
                p[i] = {p[i][3:0], p[i][7:4]};
        end
        if (game_id != `CAB_GAME_BULLET)
            p[2] = 8'hff;
        if (game_id == `CAB_GAME_DUNKSHOT)
            p[0] = {js[3][5:4], js[2][5:4], js[1][5:4], js[0][5:4]};
        case (a[13:12])
            2'd1: return a[2:1] == 2'd0 ? sys : a[2:1] == 2'd1 ? p[0] :
                         a[2:1] == 2'd2 ? p[2] : p[1];
            2'd2: return a[1] ? dip_a : dip_b;
            2'd3: begin
                if (game_id == `CAB_GAME_PASSSHT && a[9:8] == 2'd2)
                    return {js[a[2:1]][7:4], js[a[2:1]][1:0], js[a[2:1]][3:2]};
                if (game_id == `CAB_GAME_HWCHAMP && a[5:4] == 2'd2)
                    return {7'd0, ser_exp[7]};
                if (game_id == `CAB_GAME_DUNKSHOT) begin
                    idx  = a[4:2];
                    ax   = idx[0] ? sticks[idx[2:1]][15:8] : sticks[idx[2:1]][7:0];
                    step = $signed(ax) >>> 3;
                    cnt  = 12'(int'(TB_INIT[idx]) + (idx[0] ? 1 : -1) * tb_updates * step);
                    return a[1] ? {4'd0, cnt[11:8]} : cnt[7:0];
                end
            end
            default: ;
        endcase
        return 8'hff;
    endfunction

    task automatic cpu_access(input logic wr_en, input logic [23:1] a, input logic [15:0] d,
                              input logic [1:0] sel, input logic [7:0] exp);
        @(posedge clk);
        io_cs    <= 1'b1;
        addr     <= a;
        cpu_dout <= d;
        ldsn     <= 1'b0;
        udsn     <= 1'b0;
        ldswn    <= !wr_en;
        udswn    <= !wr_en;
        chk_sel  <= sel;
        chk_exp  <= exp;
        @(posedge clk);
        io_cs    <= 1'b0;
        ldsn     <= 1'b1;
        udsn     <= 1'b1;
        ldswn    <= 1'b1;
        udswn    <= 1'b1;
        chk_sel  <= 2'd0;
    endtask

    task automatic check_idle(input logic [1:0] sel, input logic [7:0] exp);
        @(posedge clk);
        chk_sel <= sel;
        chk_exp <= exp;
        @(posedge clk);
        chk_sel <= 2'd0;
    endtask

    task automatic finish_test(input int n);
        repeat (2) @(posedge clk);
        test_id   <= n;
        test_done <= 1'b1;
        @(posedge clk);
        test_done <= 1'b0;
    endtask

    task automatic shuffle_switches();
        int i;
        @(posedge clk);
        for (i = 0; i < 4; i++)
            js[i] <= 8'($random(seed));
        start_btn  <= 4'($random(seed));
        coin       <= 4'($random(seed));
        service_sw <= 1'($random(seed));
        test_sw    <= 1'($random(seed));
        dip_a      <= 8'($random(seed));
        dip_b      <= 8'($random(seed));
        repeat (4) @(posedge clk);  // Past the synchronizer
    endtask

    initial begin
        int          i;
        int          g;
        int          k;
        logic [15:0] d;
        rst        = 1'b1;
        lhbl       = 1'b1;
        game_id    = `CAB_GAME_GENERIC;
        addr       = '0;
        cpu_dout   = '0;
        ldswn      = 1'b1;
        udswn      = 1'b1;
        ldsn       = 1'b1;
        udsn       = 1'b1;
        io_cs      = 1'b0;
        service_sw = 1'b1;
        test_sw    = 1'b1;
        dip_a      = 8'hff;
        dip_b      = 8'hff;
        js         = '{default: 8'hff};
        sticks     = '{default: 16'h0000};
        stick1b    = 16'h0000;
        start_btn  = 4'hf;
        coin       = 4'hf;
        chk_sel    = 2'd0;
        chk_exp    = 8'h00;
        test_done  = 1'b0;
        test_id    = 0;
        tb_updates = 0;
        ser_exp    = 8'hff;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        // Reset state then control latch
        check_idle(2'd2, 8'h01);
        check_idle(2'd1, 8'hff);
        for (i = 0; i < 3; i++) begin
            d = 16'($random(seed));
            cpu_access(1'b1, region_addr(2'd0, 11'd0), d, 2'd2, {6'd0, d[6:5]});
        end
        finish_test(1);

        for (g = 0; g < 5; g++) begin
            game_id <= GAME_CODES[g];
            shuffle_switches();
            check_idle(2'd3, plain_sys());
            for (i = 0; i < 4; i++)
                cpu_access(1'b0, region_addr(2'd1, 11'(i)), 16'h0, 2'd1,
                           cab_expect(region_addr(2'd1, 11'(i))));
            for (i = 0; i < 2; i++)
                cpu_access(1'b0, region_addr(2'd2, 11'(i)), 16'h0, 2'd1,
                           cab_expect(region_addr(2'd2, 11'(i))));
        end
        finish_test(2);

        game_id <= `CAB_GAME_PASSSHT;
        shuffle_switches();
        for (i = 0; i < 4; i++)
            cpu_access(1'b0, region_addr(2'd3, {4'b0010, 5'd0, 2'(i)}), 16'h0, 2'd1,
                       cab_expect(region_addr(2'd3, {4'b0010, 5'd0, 2'(i)})));
        cpu_access(1'b0, region_addr(2'd3, {4'b0001, 7'd0}), 16'h0, 2'd1, 8'hff);
        finish_test(3);

        @(posedge clk);
        game_id <= `CAB_GAME_DUNKSHOT;
        for (i = 0; i < 4; i++)
            sticks[i] <= 16'($random(seed));
        k = 1 + ($unsigned($random(seed)) % MAX_EDGES);
        for (i = 0; i < k; i++) begin
            @(posedge clk);
            lhbl <= 1'b0;
            repeat (2) @(posedge clk);
            lhbl <= 1'b1;
            @(posedge clk);
        end
        tb_updates = (k - 1) / `CAB_TB_INTERVAL + 1;
        for (i = 0; i < 16; i++)
            cpu_access(1'b0, region_addr(2'd3, {7'd0, 4'(i)}), 16'h0, 2'd1,
                       cab_expect(region_addr(2'd3, {7'd0, 4'(i)})));
        finish_test(4);

        @(posedge clk);
        game_id    <= `CAB_GAME_HWCHAMP;
        sticks[0]  <= 16'($random(seed));
        stick1b    <= 16'($random(seed));
        for (g = 0; g < 4; g++) begin
            cpu_access(1'b1, region_addr(2'd3, {6'd0, 3'b100, 2'(g)}), 16'h0, 2'd0, 8'h00);
            ser_exp = load_expect(2'(g));
            for (i = 0; i < 8; i++) begin
                cpu_access(1'b0, region_addr(2'd3, {6'd0, 3'b100, 2'(g)}), 16'h0, 2'd1,
                           cab_expect(region_addr(2'd3, {6'd0, 3'b100, 2'(g)})));
                ser_exp = ser_exp << 1;  // Bit consumed MSB first
            end
        end
        finish_test(5);

        repeat (2) @(posedge clk);
        $display("Tests: 5, bad tests: %0d, checks: %0d, mismatches: %0d, assertion failures: %0d",
                 bad_tests, checks, errors, DUT.u_mux.u_asserts.fail_count);
        if (errors == 0 && bad_tests == 0 && checks > 0 && DUT.u_mux.u_asserts.fail_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // Watchdog
    initial begin
        #(2 * RUN_CYCLES * CLK_PERIOD);
        $display("Watchdog timeout, the tests did not complete in time");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* sim.f */
+incdir+include
hdl/cab_pkg.sv
hdl/cab_analog_if.sv
hdl/joy_formatter.sv
hdl/analog_unit.sv
hdl/cab_read_mux.sv
hdl/cab_io.sv
testbench/cab_io_asserts.sv
testbench/cab_checker.sv
testbench/tb_cab_io.sv
